// ==== vlog.f ====
+incdir+hdl
hdl/mmu_pkg.sv
hdl/mem_map.sv
hdl/tlb.sv
hdl/mmu_top.sv
sim/mmu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the MMU testbench with Verilator and run it.
# The simulator exits non-zero when the testbench ends in $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f \
  --top-module mmu_tb \
  -o mmu_tb_sim

./obj_dir/mmu_tb_sim

// ==== sim/mmu_tb.sv ====
`timescale 1ns/1ps
`include "mmu_defines.svh"

module mmu_tb import mmu_pkg::*; ();

  typedef logic [`MMU_PG_W-1:0] page_t;

  logic                  clk;
  logic                  arst_n;
  addr_t                 inst_address;
  addr_t                 data_address;
  logic                  inst_en;
  logic                  data_en;
  logic                  user_mode;
  asid_t                 asid;
  logic [`MMU_CFG_W-1:0] tlb_config;
  logic                  tlbwi;
  logic                  tlbp;

  addr_t  inst_paddr;
  addr_t  data_paddr;
  logic   inst_uncached;
  logic   inst_miss;
  logic   inst_illegal;
  logic   inst_invalid;
  logic   data_uncached;
  logic   data_miss;
  logic   data_illegal;
  logic   data_invalid;
  logic   data_writable;
  probe_t probe_result;

  // reference copy of the tlb contents.
  vpn2_t m_vpn2 [`MMU_TLB_ENTRIES];
  asid_t m_asid [`MMU_TLB_ENTRIES];
  logic  m_g    [`MMU_TLB_ENTRIES];
  page_t m_p0   [`MMU_TLB_ENTRIES];
  page_t m_p1   [`MMU_TLB_ENTRIES];

  logic [31:0] seed = 32'hc33d5468;

  mmu_top u_mmu_top (
    .clk                (clk),
    .arst_n_i           (arst_n),
    .inst_address_i     (inst_address),
    .data_address_i     (data_address),
    .inst_en_i          (inst_en),
    .data_en_i          (data_en),
    .user_mode_i        (user_mode),
    .asid_i             (asid),
    .tlb_config_i       (tlb_config),
    .tlbwi_i            (tlbwi),
    .tlbp_i             (tlbp),
    .inst_address_o     (inst_paddr),
    .data_address_o     (data_paddr),
    .inst_uncached_o    (inst_uncached),
    .inst_exp_miss_o    (inst_miss),
    .inst_exp_illegal_o (inst_illegal),
    .inst_exp_invalid_o (inst_invalid),
    .data_uncached_o    (data_uncached),
    .data_exp_miss_o    (data_miss),
    .data_exp_illegal_o (data_illegal),
    .data_exp_invalid_o (data_invalid),
    .data_writable_o    (data_writable),
    .tlbp_result_o      (probe_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "%s gave a wrong address", name);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      $display("Test failed");
      $fatal(1, "%s gave a wrong flag", name);
    end
  endtask

  task automatic check_probe(input string name, input probe_t exp, input probe_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "%s gave a wrong probe result", name);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [`MMU_CFG_W-1:0] make_cfg(input tlb_idx_t idx, input vpn2_t vpn2,
                                                     input asid_t as, input logic g,
                                                     input page_t p1, input page_t p0);
    logic [`MMU_CFG_W-1:0] cfg;
    cfg = '0;
    cfg[`MMU_CFG_IDX_LSB +: $bits(tlb_idx_t)] = idx;
    cfg[`MMU_CFG_VPN2_LSB +: $bits(vpn2_t)]   = vpn2;
    cfg[`MMU_CFG_ASID_LSB +: $bits(asid_t)]   = as;
    cfg[`MMU_CFG_G_BIT]                       = g;
    cfg[`MMU_CFG_P1_LSB +: `MMU_PG_W]         = p1;
    cfg[`MMU_CFG_P0_LSB +: `MMU_PG_W]         = p0;
    return cfg;
  endfunction

  function automatic page_t rand_page();
    logic [31:0] r;
    page_t pg;
    r = next_rand();
    pg = '0;
    pg[`MMU_PG_PFN_LSB +: $bits(pfn_t)] = r[31:12];
    pg[`MMU_PG_C_LSB +: $bits(cattr_t)] = r[10:8];
    pg[`MMU_PG_D_BIT] = r[7];
    pg[`MMU_PG_V_BIT] = |r[6:4]; // mostly valid pages.
    return pg;
  endfunction

  // kuseg or kseg2/3, never vpn2 zero where the reset entries sit.
  function automatic addr_t rand_mapped_addr();
    addr_t a;
    a = next_rand();
    if (a[31]) begin
      a[30] = 1'b1;
    end
    if (a[31:13] == '0) begin
      a[13] = 1'b1;
    end
    return a;
  endfunction

  function automatic addr_t entry_addr(input tlb_idx_t k);
    logic [31:0] r;
    r = next_rand();
    return {m_vpn2[k], r[12:0]};
  endfunction

  task automatic model_lookup(input addr_t va, input asid_t as, output logic hit,
                              output page_t pg);
    hit = 1'b0;
    pg = '0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (!hit && m_vpn2[i] == va[31:13] && (m_g[i] || m_asid[i] == as)) begin
        hit = 1'b1;
        pg = va[12] ? m_p1[i] : m_p0[i];
      end
    end
  endtask

  function automatic probe_t model_probe(input vpn2_t vpn2, input asid_t as);
    probe_t res;
    res = 32'h8000_0000;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (m_vpn2[i] == vpn2 && (m_g[i] || m_asid[i] == as)) begin
        res = probe_t'(i);
      end
    end
    return res;
  endfunction

  task automatic check_port(input string name, input logic is_data);
    addr_t va;
    addr_t exp_addr;
    logic  en;
    logic  illegal;
    logic  mapped;
    logic  hit;
    logic  exp_unc;
    page_t pg;
    va = is_data ? data_address : inst_address;
    en = is_data ? data_en : inst_en;
    illegal = en & user_mode & va[31];
    mapped = en & ~illegal & (va[31:30] != 2'b10);
    model_lookup(va, asid, hit, pg);
    exp_addr = (va[31:30] == 2'b10) ? {3'b000, va[28:0]} : va;
    if (mapped) begin
      exp_addr = {pg[`MMU_PG_PFN_LSB +: $bits(pfn_t)], va[`MMU_PAGE_BITS-1:0]};
    end
    exp_unc = (va[31:29] == 3'b101) ||
              (mapped && hit && pg[`MMU_PG_C_LSB +: $bits(cattr_t)] == `MMU_C_UNCACHED);
    if (is_data) begin
      if (!(mapped && !hit)) begin // the address on a miss carries no meaning.
        check_addr({name, "_addr"}, exp_addr, data_paddr);
      end
      check_flag({name, "_miss"}, mapped & ~hit, data_miss);
      check_flag({name, "_illegal"}, illegal, data_illegal);
      check_flag({name, "_invalid"}, mapped & hit & ~pg[`MMU_PG_V_BIT], data_invalid);
      check_flag({name, "_uncached"}, exp_unc, data_uncached);
      check_flag({name, "_writable"}, ~mapped | (hit & pg[`MMU_PG_D_BIT]), data_writable);
    end else begin
      if (!(mapped && !hit)) begin
        check_addr({name, "_addr"}, exp_addr, inst_paddr);
      end
      check_flag({name, "_miss"}, mapped & ~hit, inst_miss);
      check_flag({name, "_illegal"}, illegal, inst_illegal);
      check_flag({name, "_invalid"}, mapped & hit & ~pg[`MMU_PG_V_BIT], inst_invalid);
      check_flag({name, "_uncached"}, exp_unc, inst_uncached);
    end
  endtask

  task automatic run_access(input string name, input addr_t ia, input addr_t da,
                            input logic ie, input logic de, input logic um, input asid_t as);
    inst_address = ia;
    data_address = da;
    inst_en = ie;
    data_en = de;
    user_mode = um;
    asid = as;
    #10;
    check_port({name, "_inst"}, 1'b0);
    check_port({name, "_data"}, 1'b1);
    tick();
  endtask

  task automatic write_entry(input tlb_idx_t idx, input vpn2_t vpn2, input asid_t as,
                             input logic g, input page_t p1, input page_t p0);
    tlb_config = make_cfg(idx, vpn2, as, g, p1, p0);
    tlbwi = 1'b1;
    tick();
    tlbwi = 1'b0;
    m_vpn2[idx] = vpn2;
    m_asid[idx] = as;
    m_g[idx] = g;
    m_p0[idx] = p0;
    m_p1[idx] = p1;
  endtask

  // the low vpn2 bits carry the index, which keeps every written vpn2 unique.
  task automatic write_rand_entry(input tlb_idx_t idx);
    logic [31:0] r;
    vpn2_t vpn2;
    r = next_rand();
    vpn2 = {r[29:15], idx};
    if (vpn2[18]) begin
      vpn2[17] = 1'b1;
    end
    if (vpn2 == '0) begin
      vpn2[4] = 1'b1;
    end
    write_entry(idx, vpn2, r[7:0], &r[31:30], rand_page(), rand_page());
  endtask

  task automatic run_probe(input string name, input vpn2_t vpn2, input asid_t as);
    probe_t exp;
    tlb_config = make_cfg('0, vpn2, as, 1'b0, '0, '0);
    tlbp = 1'b1;
    exp = model_probe(vpn2, as);
    tick();
    tlbp = 1'b0;
    #10;
    check_probe(name, exp, probe_result);
    tick();
  endtask

  initial begin
    logic [31:0] r;
    addr_t       a;
    addr_t       b;
    tlb_idx_t    k;
    vpn2_t       new_vpn2;
    arst_n = 1'b0;
    inst_address = '0;
    data_address = '0;
    inst_en = 1'b0;
    data_en = 1'b0;
    user_mode = 1'b0;
    asid = '0;
    tlb_config = '0;
    tlbwi = 1'b0;
    tlbp = 1'b0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      m_vpn2[i] = '0;
      m_asid[i] = '0;
      m_g[i] = 1'b0;
      m_p0[i] = '0;
      m_p1[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // empty tlb after reset.
    check_probe("reset_probe_value", 32'h8000_0000, probe_result);
    a = rand_mapped_addr();
    r = next_rand();
    run_probe("reset_probe", a[31:13], r[7:0]);
    for (int n = 0; n < 16; n++) begin
      r = next_rand();
      run_access("reset_mapped", rand_mapped_addr(), rand_mapped_addr(), 1'b1, 1'b1, 1'b0,
                 r[23:16]);
    end

    // kseg0 and kseg1 are translated without the tlb.
    for (int n = 0; n < 20; n++) begin
      a = next_rand();
      b = next_rand();
      a[31:30] = 2'b10;
      b[31:30] = 2'b10;
      run_access("unmapped", a, b, 1'b1, 1'b1, 1'b0, b[7:0]);
    end

    // user mode may only reach kuseg.
    for (int n = 0; n < 20; n++) begin
      a = next_rand();
      a[31] = 1'b1;
      b = rand_mapped_addr();
      b[31] = 1'b0;
      run_access("user_mode", a, b, 1'b1, 1'b1, 1'b1, a[7:0]);
      check_flag("user_kernel_illegal", 1'b1, inst_illegal);
      check_flag("user_kuseg_legal", 1'b0, data_illegal);
    end

    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      write_rand_entry(tlb_idx_t'(i));
    end
    for (int n = 0; n < 200; n++) begin
      r = next_rand();
      k = r[27:24];
      a = (r[31] | r[28]) ? entry_addr(k) : rand_mapped_addr();
      b = (r[30] | r[28]) ? entry_addr(r[23:20]) : rand_mapped_addr();
      run_access("random_lookup", a, b, |r[19:17], |r[16:14], ~|r[13:11],
                 r[29] ? m_asid[k] : r[9:2]);
    end

    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      run_probe("probe_written", m_vpn2[i], m_asid[i]);
      run_probe("probe_other_asid", m_vpn2[i], m_asid[i] ^ 8'h5a);
    end
    for (int n = 0; n < 20; n++) begin
      a = rand_mapped_addr();
      r = next_rand();
      run_probe("probe_random", a[31:13], r[15:8]);
    end

    // rewrite one odd index under a new vpn2.
    r = next_rand();
    k = {r[3:1], 1'b1};
    a = {m_vpn2[k], 13'h0123};
    new_vpn2 = m_vpn2[k] ^ 19'h00100;
    write_entry(k, new_vpn2, m_asid[k], m_g[k], rand_page(), rand_page());
    run_access("overwrite_old", a, a, 1'b1, 1'b1, 1'b0, m_asid[k]);
    check_flag("overwrite_old_inst_miss", 1'b1, inst_miss);
    check_flag("overwrite_old_data_miss", 1'b1, data_miss);
    b = {new_vpn2, 13'h1456};
    run_access("overwrite_new", b, b, 1'b1, 1'b1, 1'b0, m_asid[k]);
    check_flag("overwrite_new_inst_hit", 1'b0, inst_miss);
    check_flag("overwrite_new_data_hit", 1'b0, data_miss);

    $display("Test passed");
    $finish;
  end

endmodule

// ==== hdl/mmu_top.sv ====
`timescale 1ns/1ps
`include "mmu_defines.svh"

module mmu_top import mmu_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  addr_t                 inst_address_i,
  input  addr_t                 data_address_i,
  input  logic                  inst_en_i,
  input  logic                  data_en_i,
  input  logic                  user_mode_i,
  input  asid_t                 asid_i,
  input  logic [`MMU_CFG_W-1:0] tlb_config_i,
  input  logic                  tlbwi_i,
  input  logic                  tlbp_i,
  output addr_t                 inst_address_o,
  output addr_t                 data_address_o,
  output logic                  inst_uncached_o,
  output logic                  inst_exp_miss_o,
  output logic                  inst_exp_illegal_o,
  output logic                  inst_exp_invalid_o,
  output logic                  data_uncached_o,
  output logic                  data_exp_miss_o,
  output logic                  data_exp_illegal_o,
  output logic                  data_exp_invalid_o,
  output logic                  data_writable_o,
  output probe_t                tlbp_result_o
);

  addr_t inst_address_direct;
  addr_t data_address_direct;
  addr_t inst_address_tlb;
  addr_t data_address_tlb;

  logic inst_tlb_map;
  logic data_tlb_map;
  logic inst_map_uncached;
  logic data_map_uncached;

  logic inst_tlb_miss;
  logic data_tlb_miss;
  logic inst_tlb_valid;
  logic data_tlb_valid;
  logic inst_tlb_uncached;
  logic data_tlb_uncached;
  logic data_tlb_dirty;

  mem_map u_map_inst (
    .addr_i      (inst_address_i),
    .en_i        (inst_en_i),
    .um_i        (user_mode_i),
    .addr_o      (inst_address_direct),
    .using_tlb_o (inst_tlb_map),
    .uncached_o  (inst_map_uncached),
    .invalid_o   (inst_exp_illegal_o)
  );

  mem_map u_map_data (
    .addr_i      (data_address_i),
    .en_i        (data_en_i),
    .um_i        (user_mode_i),
    .addr_o      (data_address_direct),
    .using_tlb_o (data_tlb_map),
    .uncached_o  (data_map_uncached),
    .invalid_o   (data_exp_illegal_o)
  );

  tlb u_tlb (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .tlb_config_i    (tlb_config_i),
    .tlbwi_i         (tlbwi_i),
    .tlbp_i          (tlbp_i),
    .asid_i          (asid_i),
    .inst_vaddr_i    (inst_address_i),
    .data_vaddr_i    (data_address_i),
    .tlbp_result_o   (tlbp_result_o),
    .inst_paddr_o    (inst_address_tlb),
    .inst_miss_o     (inst_tlb_miss),
    .inst_valid_o    (inst_tlb_valid),
    .inst_uncached_o (inst_tlb_uncached),
    .data_paddr_o    (data_address_tlb),
    .data_miss_o     (data_tlb_miss),
    .data_valid_o    (data_tlb_valid),
    .data_dirty_o    (data_tlb_dirty),
    .data_uncached_o (data_tlb_uncached)
  );

  assign inst_address_o = inst_tlb_map ? inst_address_tlb : inst_address_direct;
  assign data_address_o = data_tlb_map ? data_address_tlb : data_address_direct;

  // the mapped flag already carries the enable and excludes illegal accesses.
  assign inst_exp_miss_o    = inst_tlb_map & inst_tlb_miss;
  assign inst_exp_invalid_o = inst_tlb_map & ~inst_tlb_miss & ~inst_tlb_valid;
  assign data_exp_miss_o    = data_tlb_map & data_tlb_miss;
  assign data_exp_invalid_o = data_tlb_map & ~data_tlb_miss & ~data_tlb_valid;

  assign inst_uncached_o = inst_map_uncached | (inst_tlb_map & inst_tlb_uncached);
  assign data_uncached_o = data_map_uncached | (data_tlb_map & data_tlb_uncached);

  assign data_writable_o = ~data_tlb_map | data_tlb_dirty; // dirty is zero on a miss.

endmodule

// ==== hdl/tlb.sv ====
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tlb import mmu_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic [`MMU_CFG_W-1:0] tlb_config_i,
  input  logic                  tlbwi_i,
  input  logic                  tlbp_i,
  input  asid_t                 asid_i,
  input  addr_t                 inst_vaddr_i,
  input  addr_t                 data_vaddr_i,
  output probe_t                tlbp_result_o,
  output addr_t                 inst_paddr_o,
  output logic                  inst_miss_o,
  output logic                  inst_valid_o,
  output logic                  inst_uncached_o,
  output addr_t                 data_paddr_o,
  output logic                  data_miss_o,
  output logic                  data_valid_o,
  output logic                  data_dirty_o,
  output logic                  data_uncached_o
);

  // entry storage.
  vpn2_t                       vpn2_q [`MMU_TLB_ENTRIES];
  asid_t                       asid_q [`MMU_TLB_ENTRIES];
  logic [`MMU_TLB_ENTRIES-1:0] g_q;
  logic [`MMU_PG_W-1:0]        p0_q [`MMU_TLB_ENTRIES];
  logic [`MMU_PG_W-1:0]        p1_q [`MMU_TLB_ENTRIES];

  tlb_idx_t             cfg_idx;
  vpn2_t                cfg_vpn2;
  asid_t                cfg_asid;
  logic                 cfg_g;
  logic [`MMU_PG_W-1:0] cfg_p0;
  logic [`MMU_PG_W-1:0] cfg_p1;

  vpn2_t inst_vpn2;
  vpn2_t data_vpn2;

  logic [`MMU_TLB_ENTRIES-1:0] inst_match;
  logic [`MMU_TLB_ENTRIES-1:0] data_match;
  logic [`MMU_TLB_ENTRIES-1:0] probe_match;
  logic [`MMU_TLB_ENTRIES-1:0] live;

  tlb_idx_t             inst_idx;
  tlb_idx_t             data_idx;
  tlb_idx_t             probe_idx;
  logic                 inst_hit;
  logic                 data_hit;
  logic                 probe_hit;
  logic [`MMU_PG_W-1:0] inst_pg;
  logic [`MMU_PG_W-1:0] data_pg;

  probe_t probe_q;

  function automatic logic entry_hit(input vpn2_t e_vpn2, input asid_t e_asid,
                                     input logic e_g, input vpn2_t vpn2, input asid_t asid);
    return (e_vpn2 == vpn2) && (e_g || (e_asid == asid));
  endfunction

  // or of the indices of set bits, exact for a one-hot vector.
  function automatic tlb_idx_t enc_idx(input logic [`MMU_TLB_ENTRIES-1:0] match);
    tlb_idx_t idx;
    idx = '0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (match[i]) begin
        idx = idx | tlb_idx_t'(i);
      end
    end
    return idx;
  endfunction

  function automatic addr_t pg_paddr(input logic [`MMU_PG_W-1:0] pg, input addr_t vaddr);
    return {pg[`MMU_PG_PFN_LSB +: $bits(pfn_t)], vaddr[`MMU_PAGE_BITS-1:0]};
  endfunction

  function automatic logic pg_uncached(input logic [`MMU_PG_W-1:0] pg);
    return cattr_t'(pg[`MMU_PG_C_LSB +: $bits(cattr_t)]) == `MMU_C_UNCACHED;
  endfunction

  assign cfg_idx  = tlb_config_i[`MMU_CFG_IDX_LSB +: $bits(tlb_idx_t)];
  assign cfg_vpn2 = tlb_config_i[`MMU_CFG_VPN2_LSB +: $bits(vpn2_t)];
  assign cfg_asid = tlb_config_i[`MMU_CFG_ASID_LSB +: $bits(asid_t)];
  assign cfg_g    = tlb_config_i[`MMU_CFG_G_BIT];
  assign cfg_p1   = tlb_config_i[`MMU_CFG_P1_LSB +: `MMU_PG_W];
  assign cfg_p0   = tlb_config_i[`MMU_CFG_P0_LSB +: `MMU_PG_W];

  assign inst_vpn2 = inst_vaddr_i[31 -: $bits(vpn2_t)];
  assign data_vpn2 = data_vaddr_i[31 -: $bits(vpn2_t)];

  for (genvar i = 0; i < `MMU_TLB_ENTRIES; i++) begin : g_match
    assign inst_match[i]  = entry_hit(vpn2_q[i], asid_q[i], g_q[i], inst_vpn2, asid_i);
    assign data_match[i]  = entry_hit(vpn2_q[i], asid_q[i], g_q[i], data_vpn2, asid_i);
    assign probe_match[i] = entry_hit(vpn2_q[i], asid_q[i], g_q[i], cfg_vpn2, cfg_asid);
    assign live[i]        = p0_q[i][`MMU_PG_V_BIT] | p1_q[i][`MMU_PG_V_BIT];
  end

  assign inst_hit  = |inst_match;
  assign data_hit  = |data_match;
  assign probe_hit = |probe_match;
  assign inst_idx  = enc_idx(inst_match);
  assign data_idx  = enc_idx(data_match);
  assign probe_idx = enc_idx(probe_match);

  // bit 12 of the address picks the even or odd page of the pair.
  assign inst_pg = inst_vaddr_i[`MMU_PAGE_BITS] ? p1_q[inst_idx] : p0_q[inst_idx];
  assign data_pg = data_vaddr_i[`MMU_PAGE_BITS] ? p1_q[data_idx] : p0_q[data_idx];

  assign inst_paddr_o    = pg_paddr(inst_pg, inst_vaddr_i);
  assign inst_miss_o     = ~inst_hit;
  assign inst_valid_o    = inst_hit & inst_pg[`MMU_PG_V_BIT];
  assign inst_uncached_o = inst_hit & pg_uncached(inst_pg);

  assign data_paddr_o    = pg_paddr(data_pg, data_vaddr_i);
  assign data_miss_o     = ~data_hit;
  assign data_valid_o    = data_hit & data_pg[`MMU_PG_V_BIT];
  assign data_dirty_o    = data_hit & data_pg[`MMU_PG_D_BIT];
  assign data_uncached_o = data_hit & pg_uncached(data_pg);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
        vpn2_q[i] <= '0;
        asid_q[i] <= '0;
        p0_q[i]   <= '0;
        p1_q[i]   <= '0;
      end
      g_q <= '0;
    end else if (tlbwi_i) begin
      vpn2_q[cfg_idx] <= cfg_vpn2;
      asid_q[cfg_idx] <= cfg_asid;
      g_q[cfg_idx]    <= cfg_g;
      p0_q[cfg_idx]   <= cfg_p0;
      p1_q[cfg_idx]   <= cfg_p1;
    end
  end

  // probe result holds until the next tlbp.
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      probe_q <= 32'h8000_0000;
    end else if (tlbp_i) begin
      probe_q <= {~probe_hit, {(31 - $bits(tlb_idx_t)){1'b0}}, probe_idx};
    end
  end

  assign tlbp_result_o = probe_q;

  // tlbwi and tlbp come from different instructions and never share a cycle.
  a_strobe_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(tlbwi_i && tlbp_i));

  // Entries left from reset all alias at vpn2 zero. Among entries with a valid
  // page, software keeps the vpn2/asid pairs unique.
  a_inst_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
    $onehot0(inst_match & live));
  a_data_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
    $onehot0(data_match & live));
  a_probe_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
    tlbp_i |-> $onehot0(probe_match & live));

endmodule

// ==== hdl/mem_map.sv ====
`timescale 1ns/1ps

module mem_map import mmu_pkg::*; (
  input  addr_t addr_i,
  input  logic  en_i,
  input  logic  um_i,
  output addr_t addr_o,
  output logic  using_tlb_o,
  output logic  uncached_o,
  output logic  invalid_o
);

  logic seg_kuseg;
  logic seg_kseg0;
  logic seg_kseg1;
  logic seg_kseg23;

  // segment decode from the top three address bits.
  always_comb begin
    seg_kuseg  = ~addr_i[31];                 // 0x0000_0000 to 0x7fff_ffff.
    seg_kseg0  = (addr_i[31:29] == 3'b100);   // unmapped, cached.
    seg_kseg1  = (addr_i[31:29] == 3'b101);   // unmapped, uncached.
    seg_kseg23 = (addr_i[31:30] == 2'b11);    // mapped kernel space.
    invalid_o   = en_i & um_i & addr_i[31]; // user code touching kernel space.
    using_tlb_o = en_i & (seg_kuseg | (seg_kseg23 & ~um_i)); // kseg2/3 only in kernel mode.
    uncached_o  = seg_kseg1;
    addr_o      = addr_i;
    if (seg_kseg0 || seg_kseg1) begin
      addr_o = {3'b000, addr_i[28:0]}; // both windows alias the low 512 MB.
    end
  end

  // An illegal access is handled as unmapped, so it can never raise a tlb miss
  // at the top level.
  always_comb begin
    assert (!(invalid_o && using_tlb_o))
      else $error("mem_map: illegal access routed to the tlb.");
  end

endmodule

// ==== hdl/mmu_pkg.sv ====
`include "mmu_defines.svh"

package mmu_pkg;

  // virtual or physical byte address.
  typedef logic [31:0] addr_t;

  // a tlb entry maps an even/odd pair of pages, so vpn2 drops the page select bit.
  typedef logic [30-`MMU_PAGE_BITS:0] vpn2_t;

  typedef logic [31-`MMU_PAGE_BITS:0] pfn_t; // physical frame number.

  typedef logic [7:0] asid_t; // address space identifier.

  typedef logic [$clog2(`MMU_TLB_ENTRIES)-1:0] tlb_idx_t;

  typedef logic [2:0] cattr_t; // cache attribute, 2 means uncached.

  // bit 31 flags a probe miss, the low bits carry the index on a hit.
  typedef logic [31:0] probe_t;

endpackage

// ==== hdl/mmu_defines.svh ====
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

`define MMU_TLB_ENTRIES 16
`define MMU_PAGE_BITS   12 // 4 KB pages only.

`define MMU_CFG_W        82
`define MMU_CFG_IDX_LSB  78
`define MMU_CFG_VPN2_LSB 59
`define MMU_CFG_ASID_LSB 51
`define MMU_CFG_G_BIT    50
`define MMU_CFG_P1_LSB   25 // odd page of the pair.
`define MMU_CFG_P0_LSB   0

`define MMU_PG_W       25 // pfn, cache attribute, dirty, valid.
`define MMU_PG_PFN_LSB 5
`define MMU_PG_C_LSB   2
`define MMU_PG_D_BIT   1
`define MMU_PG_V_BIT   0

`define MMU_C_UNCACHED 3'd2

`endif
